/* hw/memBusPkg.sv */
package memBusPkg;

    // request side address and data
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    // result tag that travels with each access
    localparam int TagWidth = 4;

    // the RAM holds 2**MemAddrWidth bytes and addresses wrap around it
    localparam int MemAddrWidth = 10;

    localparam int LenWidth = 2;

    // a load word is filled one byte at a time and handed back as a whole word
    typedef union packed {
        logic [DataWidth-1:0] word;
        // byte 0 is the least significant byte
        logic [3:0][7:0] bytes;
    } loadWord_u;

endpackage

/* hw/memCtrlPkg.sv */
package memCtrlPkg;

    typedef enum logic [1:0] {
        Idle = 2'd0,
        Xfer = 2'd1,
        Done = 2'd2
    } memState_e;

    // length codes, the code 2'd3 is not a valid length
    localparam logic [memBusPkg::LenWidth-1:0] LenByte = 2'd0;
    localparam logic [memBusPkg::LenWidth-1:0] LenHalf = 2'd1;
    localparam logic [memBusPkg::LenWidth-1:0] LenWord = 2'd2;

endpackage

/* hw/dataCache.sv */
`timescale 1ns/1ns

module dataCache (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              reqEn,
    input  logic                              reqStore,
    input  logic [memBusPkg::AddrWidth-1:0]   reqAddr,
    input  logic [memBusPkg::DataWidth-1:0]   reqData,
    input  logic [memBusPkg::LenWidth-1:0]    reqLen,
    input  logic [memBusPkg::TagWidth-1:0]    reqTag,
    output logic                              reqReady,
    input  logic                              mcBusy,
    input  logic                              mcDone,
    input  logic [memBusPkg::DataWidth-1:0]   mcRdData,
    output logic                              mcEn,
    output logic                              mcStore,
    output logic [memBusPkg::AddrWidth-1:0]   mcAddr,
    output logic [memBusPkg::DataWidth-1:0]   mcData,
    output logic [memBusPkg::LenWidth-1:0]    mcLen,
    output logic                              respDone,
    output logic [memBusPkg::DataWidth-1:0]   respData,
    output logic [memBusPkg::TagWidth-1:0]    respTag
);
    logic                              occupied;
    logic                              heldStore;
    logic [memBusPkg::AddrWidth-1:0]   heldAddr;
    logic [memBusPkg::DataWidth-1:0]   heldData;
    logic [memBusPkg::LenWidth-1:0]    heldLen;
    logic [memBusPkg::TagWidth-1:0]    heldTag;
    logic                              accept;

    assign reqReady = rdy && !occupied;
    assign accept   = reqEn && reqReady;

    // the held access is offered until the controller picks it up
    assign mcEn    = occupied && !mcBusy;
    assign mcStore = heldStore;
    assign mcAddr  = heldAddr;
    assign mcData  = heldData;
    assign mcLen   = heldLen;

    // a store leaves the assembled word at zero, so the data needs no select
    assign respDone = mcDone && rdy;
    assign respData = mcRdData;
    assign respTag  = heldTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
        end else if (rdy) begin
            if (mcDone) begin
                occupied <= 1'b0;
            end else if (accept) begin
                occupied <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldStore <= reqStore;
            heldAddr  <= reqAddr;
            heldData  <= reqData;
            heldLen   <= reqLen;
            heldTag   <= reqTag;
        end
    end

endmodule

/* hw/memController.sv */
`timescale 1ns/1ns

module memController (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdy,
    input  logic                            mcEn,
    input  logic                            mcStore,
    input  logic [memBusPkg::LenWidth-1:0]  mcLen,
    input  logic                            lastByte,
    output logic                            mcBusy,
    output logic                            mcDone,
    output logic                            cntClear,
    output logic                            cntStep,
    output logic                            ramWe,
    output logic                            asmClear,
    output logic                            asmCapture
);
    import memCtrlPkg::*;

    memState_e state;
    memState_e nextState;
    logic      lenValid;

    // an unknown length code moves no bytes and completes straight away
    assign lenValid = (mcLen == LenByte) || (mcLen == LenHalf) || (mcLen == LenWord);

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (mcEn) begin
                    nextState = lenValid ? Xfer : Done;
                end
            end
            Xfer: begin
                if (lastByte) begin
                    nextState = Done;
                end
            end
            Done: begin
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else if (rdy) begin
            state <= nextState;
        end
    end

    assign mcBusy = (state != Idle);
    assign mcDone = (state == Done);

    // counter and assembler restart on the edge that leaves Idle
    assign cntClear = (state == Idle) && mcEn;
    assign asmClear = (state == Idle) && mcEn;

    // one byte per cycle in Xfer, writes are held off while frozen
    assign cntStep    = (state == Xfer);
    assign ramWe      = (state == Xfer) && mcStore && rdy;
    assign asmCapture = (state == Xfer) && !mcStore;

endmodule

/* hw/byteCounter.sv */
`timescale 1ns/1ns

module byteCounter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdy,
    input  logic                            cntClear,
    input  logic                            cntStep,
    input  logic [memBusPkg::LenWidth-1:0]  mcLen,
    output logic [1:0]                      byteIdx,
    output logic                            lastByte
);
    import memCtrlPkg::*;

    logic [1:0] lastIdx;

    always_ff @(posedge clk) begin
        if (rst) begin
            byteIdx <= 2'd0;
        end else if (rdy) begin
            if (cntClear) begin
                byteIdx <= 2'd0;
            end else if (cntStep) begin
                byteIdx <= byteIdx + 2'd1;
            end
        end
    end

    // index of the final byte for each length
    always_comb begin
        case (mcLen)
            LenByte: lastIdx = 2'd0;
            LenHalf: lastIdx = 2'd1;
            default: lastIdx = 2'd3;
        endcase
    end

    assign lastByte = (byteIdx == lastIdx);

endmodule

/* hw/byteAssembler.sv */
`timescale 1ns/1ns

module byteAssembler (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rdy,
    input  logic                             asmClear,
    input  logic                             asmCapture,
    input  logic [1:0]                       byteIdx,
    input  logic [7:0]                       ramRdByte,
    output logic [memBusPkg::DataWidth-1:0]  mcRdData
);
    import memBusPkg::*;

    loadWord_u loadWord;

    // clearing first makes the bytes a short load never touches read as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            loadWord.word <= '0;
        end else if (rdy) begin
            if (asmClear) begin
                loadWord.word <= '0;
            end else if (asmCapture) begin
                loadWord.bytes[byteIdx] <= ramRdByte;
            end
        end
    end

    assign mcRdData = loadWord.word;

endmodule

/* hw/byteRam.sv */
`timescale 1ns/1ns

module byteRam (
    input  logic                               clk,
    input  logic                               ramWe,
    input  logic [memBusPkg::MemAddrWidth-1:0] ramAddr,
    input  logic [7:0]                         ramWrByte,
    output logic [7:0]                         ramRdByte
);
    import memBusPkg::*;

    localparam int Depth = 2 ** MemAddrWidth;

    logic [7:0] mem [Depth];

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWrByte;
        end
    end

    // read is combinational so a byte lands in the assembler on the same edge
    assign ramRdByte = mem[ramAddr];

endmodule

/* hw/memSubsystem.sv */
`timescale 1ns/1ns

module memSubsystem (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              reqEn,
    input  logic                              reqStore,
    input  logic [memBusPkg::AddrWidth-1:0]   reqAddr,
    input  logic [memBusPkg::DataWidth-1:0]   reqData,
    input  logic [memBusPkg::LenWidth-1:0]    reqLen,
    input  logic [memBusPkg::TagWidth-1:0]    reqTag,
    output logic                              reqReady,
    output logic                              respDone,
    output logic [memBusPkg::DataWidth-1:0]   respData,
    output logic [memBusPkg::TagWidth-1:0]    respTag
);
    import memBusPkg::*;

    logic                    mcEn;
    logic                    mcStore;
    logic [AddrWidth-1:0]    mcAddr;
    logic [DataWidth-1:0]    mcData;
    logic [LenWidth-1:0]     mcLen;
    logic                    mcBusy;
    logic                    mcDone;
    logic [DataWidth-1:0]    mcRdData;
    logic                    cntClear;
    logic                    cntStep;
    logic                    ramWe;
    logic                    asmClear;
    logic                    asmCapture;
    logic [1:0]              byteIdx;
    logic                    lastByte;
    logic [MemAddrWidth-1:0] ramAddr;
    logic [7:0]              ramWrByte;
    logic [7:0]              ramRdByte;

    // little-endian byte lane, the address wraps at the RAM size
    assign ramAddr   = mcAddr[MemAddrWidth-1:0] + MemAddrWidth'(byteIdx);
    assign ramWrByte = mcData[byteIdx*8 +: 8];

    dataCache dataCache_i (
        .clk, .rst, .rdy,
        .reqEn, .reqStore, .reqAddr, .reqData, .reqLen, .reqTag, .reqReady,
        .mcBusy, .mcDone, .mcRdData,
        .mcEn, .mcStore, .mcAddr, .mcData, .mcLen,
        .respDone, .respData, .respTag
    );

    memController memController_i (
        .clk, .rst, .rdy,
        .mcEn, .mcStore, .mcLen, .lastByte,
        .mcBusy, .mcDone, .cntClear, .cntStep, .ramWe, .asmClear, .asmCapture
    );

    byteCounter byteCounter_i (
        .clk, .rst, .rdy, .cntClear, .cntStep, .mcLen, .byteIdx, .lastByte
    );

    byteAssembler byteAssembler_i (
        .clk, .rst, .rdy, .asmClear, .asmCapture, .byteIdx, .ramRdByte, .mcRdData
    );

    byteRam byteRam_i (
        .clk, .ramWe, .ramAddr, .ramWrByte, .ramRdByte
    );

endmodule

/* test/memSubsystem_assertions.sv */
`timescale 1ns/1ns

module memSubsystem_assertions (
    input logic                            clk,
    input logic                            rst,
    input logic                            rdy,
    input logic                            reqEn,
    input logic                            reqReady,
    input logic [memBusPkg::LenWidth-1:0]  reqLen,
    input logic                            respDone
);
    import memCtrlPkg::*;

    int         failCount = 0;
    logic       seenReq;
    logic       busy;
    logic       stalled;
    logic [7:0] waitCnt;
    logic [7:0] expLat;
    logic       accept;

    // cycles from the accepting edge to the edge that samples respDone
    function automatic logic [7:0] latencyFor(input logic [1:0] len);
        case (len)
            LenByte: return 8'd3;
            LenHalf: return 8'd4;
            default: return 8'd6;
        endcase
    endfunction

    assign accept = reqEn && reqReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            seenReq <= 1'b0;
            busy    <= 1'b0;
            stalled <= 1'b0;
            waitCnt <= 8'd0;
            expLat  <= 8'd0;
        end else if (accept) begin
            seenReq <= 1'b1;
            busy    <= 1'b1;
            stalled <= 1'b0;
            waitCnt <= 8'd1;
            expLat  <= latencyFor(reqLen);
        end else if (busy) begin
            if (respDone) begin
                busy <= 1'b0;
            end
            if (!rdy) begin
                stalled <= 1'b1;
            end
            waitCnt <= waitCnt + 8'd1;
        end
    end

    idleAfterReset: assert property (@(posedge clk) disable iff (rst)
        !seenReq |-> reqReady && !respDone)
        else begin
            failCount++;
            $error("idle state after reset not held");
        end

    responseLatency: assert property (@(posedge clk) disable iff (rst)
        respDone && busy && !stalled |-> waitCnt == expLat)
        else begin
            failCount++;
            $error("response latency differs from n+2");
        end

    notReadyWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !reqReady)
        else begin
            failCount++;
            $error("reqReady high while an access is held");
        end

    singlePulse: assert property (@(posedge clk) disable iff (rst)
        respDone |=> !respDone)
        else begin
            failCount++;
            $error("respDone high for two cycles");
        end

endmodule

bind memSubsystem memSubsystem_assertions memSubsystem_assertions_i (.*);

/* test/memSubsystemTb.sv */
`timescale 1ns/1ns

module memSubsystemTb;
    import memBusPkg::*;
    import memCtrlPkg::*;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 rdy;
    logic                 reqEn;
    logic                 reqStore;
    logic [AddrWidth-1:0] reqAddr;
    logic [DataWidth-1:0] reqData;
    logic [LenWidth-1:0]  reqLen;
    logic [TagWidth-1:0]  reqTag;
    logic                 reqReady;
    logic                 respDone;
    logic [DataWidth-1:0] respData;
    logic [TagWidth-1:0]  respTag;

    logic [7:0] shadow [1024];
    logic [31:0] lcgState = 32'h8358;
    int          timeoutCycles = 100;

    memSubsystem memSubsystem_i (.*);

    always #4 clk = ~clk;

    always @(memSubsystem_i.memSubsystem_assertions_i.failCount) begin
        if (memSubsystem_i.memSubsystem_assertions_i.failCount != 0) begin
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // fill byte mixes every address bit so aliasing shows up
    function automatic logic [7:0] fillByte(input logic [9:0] a);
        return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5a;
    endfunction

    function automatic int byteCount(input logic [1:0] len);
        case (len)
            LenByte: return 1;
            LenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    task automatic stopOnFailure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic runAccess(input string testName, input logic store,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] len, input logic [3:0] tag,
                             input int stallAfter);
        loadWord_u   expWord;
        logic [9:0]  a;
        logic [31:0] held;
        int          n;
        int          cnt;
        n = byteCount(len);
        expWord.word = '0;
        for (int i = 0; i < n; i++) begin
            a = addr[9:0] + 10'(i);
            if (store) begin
                shadow[a] = data[i*8 +: 8];
            end else begin
                expWord.bytes[i] = shadow[a];
            end
        end
        cnt = 0;
        while (!reqReady) begin
            cnt++;
            if (cnt > timeoutCycles) begin
                stopOnFailure("timeout waiting for reqReady");
            end
            @(posedge clk);
            #1;
        end
        reqEn = 1'b1;
        reqStore = store;
        reqAddr = addr;
        reqData = data;
        reqLen = len;
        reqTag = tag;
        @(posedge clk);
        #1;
        reqEn = 1'b0;
        if (stallAfter >= 0) begin
            repeat (stallAfter) begin
                @(posedge clk);
                #1;
            end
            rdy = 1'b0;
            held = respData;
            repeat (3) begin
                @(negedge clk);
                assert (!respDone)
                    else stopOnFailure({testName, ": respDone high while rdy is low"});
                assert (respData == held)
                    else stopOnFailure($sformatf("Mismatch %s: expected %h actual %h",
                                                 testName, held, respData));
                @(posedge clk);
                #1;
            end
            rdy = 1'b1;
        end
        cnt = 0;
        @(negedge clk);
        while (!respDone) begin
            cnt++;
            if (cnt > timeoutCycles) begin
                stopOnFailure("timeout waiting for respDone");
            end
            @(negedge clk);
        end
        assert (respData == expWord.word)
            else stopOnFailure($sformatf("Mismatch %s: expected %h actual %h",
                                         testName, expWord.word, respData));
        assert (respTag == tag)
            else stopOnFailure($sformatf("Mismatch %s tag: expected %h actual %h",
                                         testName, tag, respTag));
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  len;
        rst = 1'b1;
        rdy = 1'b1;
        reqEn = 1'b0;
        reqStore = 1'b0;
        reqAddr = '0;
        reqData = '0;
        reqLen = LenByte;
        reqTag = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // idle a while so the post-reset check sees several cycles
        repeat (4) @(posedge clk);
        #1;
        for (int w = 0; w < 256; w++) begin
            addr = 32'(w * 4);
            data = {fillByte(10'(w*4+3)), fillByte(10'(w*4+2)),
                    fillByte(10'(w*4+1)), fillByte(10'(w*4))};
            runAccess("fill", 1'b1, addr, data, LenWord, 4'(w), -1);
        end
        runAccess("wordStore", 1'b1, 32'h0000_0104, 32'hcafe_f00d, LenWord, 4'h3, -1);
        runAccess("wordLoad", 1'b0, 32'h0000_0104, 32'h0, LenWord, 4'h9, -1);
        for (int k = 0; k < 200; k++) begin
            len = 2'(nextRand() % 3);
            addr = nextRand();
            data = nextRand();
            runAccess("random", nextRand() % 2 == 0, addr, data, len, 4'(nextRand()), -1);
        end
        // the stall may start in any cycle from the one after acceptance to the done cycle
        for (int k = 0; k < 20; k++) begin
            len = 2'(nextRand() % 3);
            addr = nextRand();
            data = nextRand();
            runAccess("stall", k % 2 == 0, addr, data, len, 4'(k),
                      int'(nextRand() % 32'(byteCount(len) + 2)));
        end
        repeat (3) @(posedge clk);
        if (memSubsystem_i.memSubsystem_assertions_i.failCount == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

/* files.f */
hw/memBusPkg.sv
hw/memCtrlPkg.sv
hw/dataCache.sv
hw/memController.sv
hw/byteCounter.sv
hw/byteAssembler.sv
hw/byteRam.sv
hw/memSubsystem.sv
test/memSubsystem_assertions.sv
test/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build and run the memSubsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module memSubsystemTb -f files.f -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation returned a failing status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1
